/* run_sim.sh */
#!/usr/bin/env bash
# Build the front-end testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_rv32i_front_end -f rv32i_front_end.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { echo "Build or simulation run failed"; exit 1; }

cat sim.log
grep -qx "NO ERRORS" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* rv32i_front_end.f */
source/rv32i_pkg.sv
source/fetch_unit.sv
source/ifid_reg.sv
source/instr_fields.sv
source/imm_gen.sv
source/id_stage_reg.sv
source/rv32i_front_end.sv
tb/wb_imem_model.sv
tb/tb_rv32i_front_end.sv

/* source/fetch_unit.sv */
/*
 * Instruction fetch over a read-only Wishbone classic master
 * Holds the PC and parks one word in a skid buffer during a stall
 */
`default_nettype none

module fetch_unit (
    input  wire         clk,
    input  wire         rst,
    input  wire         take,
    input  wire         redirect,
    input  wire  [31:0] redirect_pc,
    output logic        wb_cyc,
    output logic        wb_stb,
    output logic [31:0] wb_adr,
    input  wire  [31:0] wb_dat_i,
    input  wire         wb_ack,
    output logic        fetch_valid,
    output logic [31:0] fetch_pc,
    output logic [31:0] fetch_instr
);
    import rv32i_pkg::*;

    logic [31:0] pc;
    logic        bus_active;
    logic        bus_done;
    logic        skid_valid;
    logic [31:0] skid_pc;
    logic [31:0] skid_instr;

    assign bus_done = bus_active & wb_ack;

    // cyc and stb rise and fall together, address is the PC
    assign wb_cyc = bus_active;
    assign wb_stb = bus_active;
    assign wb_adr = pc;

    // Bus is idle while the skid buffer holds a word
    assign fetch_valid = skid_valid | bus_done;
    assign fetch_pc    = skid_valid ? skid_pc : pc;
    assign fetch_instr = skid_valid ? skid_instr : wb_dat_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc         <= reset_vector;
            bus_active <= 1'b0;
            skid_valid <= 1'b0;
        end else if (redirect) begin
            // Drop cyc to abort, restart next cycle on the new path
            pc         <= redirect_pc;
            bus_active <= 1'b0;
            skid_valid <= 1'b0;
        end else if (bus_done) begin
            pc <= pc + 32'd4;
            if (!take) begin
                // Next stage busy, park the word
                bus_active <= 1'b0;
                skid_valid <= 1'b1;
            end
        end else if (skid_valid) begin
            if (take) begin
                skid_valid <= 1'b0;
                bus_active <= 1'b1;
            end
        end else if (!bus_active) begin
            bus_active <= 1'b1;
        end
    end

    // Capture the word that arrived while stalled
    always_ff @(posedge clk) begin
        if (bus_done && !take && !redirect) begin
            skid_pc    <= pc;
            skid_instr <= wb_dat_i;
        end
    end

endmodule

`default_nettype wire

/* source/id_stage_reg.sv */
/*
 * ID/EX register, joins the field and immediate decode
 * Adds the branch or jump target before registering the bundle
 */
`default_nettype none

module id_stage_reg (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            en,
    input  wire                            flush,
    input  wire                            ifid_valid,
    input  wire  [31:0]                    ifid_pc,
    input  wire  rv32i_pkg::rv32i_opcode_e opcode,
    input  wire  [2:0]                     funct3,
    input  wire  [6:0]                     funct7,
    input  wire  rv32i_pkg::rv32i_reg_t    rs1,
    input  wire  rv32i_pkg::rv32i_reg_t    rs2,
    input  wire  rv32i_pkg::rv32i_reg_t    rd,
    input  wire  rv32i_pkg::instr_format_e format,
    input  wire                            illegal,
    input  wire  [31:0]                    imm,
    output logic                           id_valid,
    output logic [31:0]                    id_pc,
    output rv32i_pkg::rv32i_opcode_e       id_opcode,
    output logic [2:0]                     id_funct3,
    output logic [6:0]                     id_funct7,
    output rv32i_pkg::rv32i_reg_t          id_rs1,
    output rv32i_pkg::rv32i_reg_t          id_rs2,
    output rv32i_pkg::rv32i_reg_t          id_rd,
    output rv32i_pkg::instr_format_e       id_format,
    output logic [31:0]                    id_imm,
    output logic [31:0]                    id_target,
    output logic                           id_illegal
);
    import rv32i_pkg::*;

    logic [31:0] target;

    // PC relative target for branches and JAL only
    assign target = (format == fmt_b || format == fmt_j) ? ifid_pc + imm : 32'd0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            id_valid <= 1'b0;
        end else if (flush) begin
            id_valid <= 1'b0;
        end else if (en) begin
            id_valid <= ifid_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (en && !flush) begin
            id_pc      <= ifid_pc;
            id_opcode  <= opcode;
            id_funct3  <= funct3;
            id_funct7  <= funct7;
            id_rs1     <= rs1;
            id_rs2     <= rs2;
            id_rd      <= rd;
            id_format  <= format;
            id_imm     <= imm;
            id_target  <= target;
            id_illegal <= illegal;
        end
    end

endmodule

`default_nettype wire

/* source/ifid_reg.sv */
/*
 * IF/ID pipeline register
 * Holds when disabled, loads a NOP with valid low on flush
 */
`default_nettype none

module ifid_reg (
    input  wire         clk,
    input  wire         rst,
    input  wire         en,
    input  wire         flush,
    input  wire         fetch_valid,
    input  wire  [31:0] fetch_pc,
    input  wire  [31:0] fetch_instr,
    output logic        ifid_valid,
    output logic [31:0] ifid_pc,
    output logic [31:0] ifid_instr
);
    import rv32i_pkg::*;

    // Flush wins over a stall
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ifid_valid <= 1'b0;
        end else if (flush) begin
            ifid_valid <= 1'b0;
        end else if (en) begin
            ifid_valid <= fetch_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (flush) begin
            ifid_instr <= nop_instr;
        end else if (en) begin
            ifid_pc    <= fetch_pc;
            ifid_instr <= fetch_instr;
        end
    end

endmodule

`default_nettype wire

/* source/imm_gen.sv */
/*
 * Immediate generator, builds all formats and selects one
 */
`default_nettype none

module imm_gen (
    input  wire rv32i_pkg::rv32i_instr_u  ifid_instr,
    input  wire rv32i_pkg::instr_format_e format,
    output logic [31:0]                   imm
);
    import rv32i_pkg::*;

    logic [31:0] i_imm;
    logic [31:0] s_imm;
    logic [31:0] b_imm;
    logic [31:0] u_imm;
    logic [31:0] j_imm;

    // Sign bit is always instruction bit 31
    assign i_imm = {{20{ifid_instr.i_fmt.imm_11_0[11]}}, ifid_instr.i_fmt.imm_11_0};
    assign s_imm = {{20{ifid_instr.s_fmt.imm_11_5[6]}}, ifid_instr.s_fmt.imm_11_5,
                    ifid_instr.s_fmt.imm_4_0};
    assign b_imm = {{19{ifid_instr.b_fmt.imm_12}}, ifid_instr.b_fmt.imm_12,
                    ifid_instr.b_fmt.imm_11, ifid_instr.b_fmt.imm_10_5,
                    ifid_instr.b_fmt.imm_4_1, 1'b0};
    assign u_imm = {ifid_instr.u_fmt.imm_31_12, 12'd0};
    assign j_imm = {{11{ifid_instr.j_fmt.imm_20}}, ifid_instr.j_fmt.imm_20,
                    ifid_instr.j_fmt.imm_19_12, ifid_instr.j_fmt.imm_11,
                    ifid_instr.j_fmt.imm_10_1, 1'b0};

    always_comb begin
        case (format)
            fmt_i:   imm = i_imm;
            fmt_s:   imm = s_imm;
            fmt_b:   imm = b_imm;
            fmt_u:   imm = u_imm;
            fmt_j:   imm = j_imm;
            default: imm = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

/* source/instr_fields.sv */
/*
 * Field decoder for the IF/ID word
 * Names the fields, picks the format and flags unknown opcodes
 */
`default_nettype none

module instr_fields (
    input  wire rv32i_pkg::rv32i_instr_u  ifid_instr,
    output rv32i_pkg::rv32i_opcode_e      opcode,
    output logic [2:0]                    funct3,
    output logic [6:0]                    funct7,
    output rv32i_pkg::rv32i_reg_t         rs1,
    output rv32i_pkg::rv32i_reg_t         rs2,
    output rv32i_pkg::rv32i_reg_t         rd,
    output rv32i_pkg::instr_format_e      format,
    output logic                          illegal
);
    import rv32i_pkg::*;

    logic [6:0] raw_opcode;
    logic       known;

    assign raw_opcode = ifid_instr.r_fmt.opcode;
    assign opcode     = rv32i_opcode_e'(raw_opcode);

    always_comb begin
        known  = 1'b1;
        format = fmt_i;
        case (raw_opcode)
            opc_op:       format = fmt_r;
            opc_op_imm,
            opc_load,
            opc_jalr,
            opc_misc_mem,
            opc_system:   format = fmt_i;
            opc_store:    format = fmt_s;
            opc_branch:   format = fmt_b;
            opc_lui,
            opc_auipc:    format = fmt_u;
            opc_jal:      format = fmt_j;
            default:      known = 1'b0;
        endcase
    end

    // Every base opcode ends in 2'b11, other low bits fall to the default arm
    assign illegal = ~known;

    // rs1 and funct3 sit at fixed bits and pass through as they are
    assign rs1    = ifid_instr.r_fmt.rs1;
    assign funct3 = ifid_instr.r_fmt.funct3;

    // Zero the absent fields so no false dependency shows downstream
    assign funct7 = (format == fmt_r) ? ifid_instr.r_fmt.funct7 : 7'd0;
    assign rs2    = (format == fmt_r || format == fmt_s || format == fmt_b)
                    ? ifid_instr.r_fmt.rs2 : 5'd0;
    assign rd     = (format == fmt_s || format == fmt_b) ? 5'd0 : ifid_instr.r_fmt.rd;

endmodule

`default_nettype wire

/* source/rv32i_front_end.sv */
/*
 * RV32I front end: fetch, IF/ID register and decode into ID/EX
 */
`default_nettype none

module rv32i_front_end (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      stall,
    input  wire                      redirect,
    input  wire  [31:0]              redirect_pc,
    output logic                     wb_cyc,
    output logic                     wb_stb,
    output logic [31:0]              wb_adr,
    input  wire  [31:0]              wb_dat_i,
    input  wire                      wb_ack,
    output logic                     id_valid,
    output logic [31:0]              id_pc,
    output rv32i_pkg::rv32i_opcode_e id_opcode,
    output logic [2:0]               id_funct3,
    output logic [6:0]               id_funct7,
    output rv32i_pkg::rv32i_reg_t    id_rs1,
    output rv32i_pkg::rv32i_reg_t    id_rs2,
    output rv32i_pkg::rv32i_reg_t    id_rd,
    output rv32i_pkg::instr_format_e id_format,
    output logic [31:0]              id_imm,
    output logic [31:0]              id_target,
    output logic                     id_illegal
);
    import rv32i_pkg::*;

    logic          take;
    logic          fetch_valid;
    logic [31:0]   fetch_pc;
    logic [31:0]   fetch_instr;
    logic          ifid_valid;
    logic [31:0]   ifid_pc;
    rv32i_instr_u  ifid_instr;
    rv32i_opcode_e dec_opcode;
    logic [2:0]    dec_funct3;
    logic [6:0]    dec_funct7;
    rv32i_reg_t    dec_rs1;
    rv32i_reg_t    dec_rs2;
    rv32i_reg_t    dec_rd;
    instr_format_e dec_format;
    logic          dec_illegal;
    logic [31:0]   dec_imm;

    // One stall signal freezes fetch hand-off and both registers
    assign take = ~stall;

    fetch_unit i_fetch_unit (
        .clk, .rst, .take, .redirect, .redirect_pc,
        .wb_cyc, .wb_stb, .wb_adr, .wb_dat_i, .wb_ack,
        .fetch_valid, .fetch_pc, .fetch_instr
    );

    ifid_reg i_ifid_reg (
        .clk, .rst, .en(take), .flush(redirect),
        .fetch_valid, .fetch_pc, .fetch_instr,
        .ifid_valid, .ifid_pc, .ifid_instr
    );

    instr_fields i_instr_fields (
        .ifid_instr, .opcode(dec_opcode), .funct3(dec_funct3), .funct7(dec_funct7),
        .rs1(dec_rs1), .rs2(dec_rs2), .rd(dec_rd), .format(dec_format),
        .illegal(dec_illegal)
    );

    imm_gen i_imm_gen (.ifid_instr, .format(dec_format), .imm(dec_imm));

    id_stage_reg i_id_stage_reg (
        .clk, .rst, .en(take), .flush(redirect), .ifid_valid, .ifid_pc,
        .opcode(dec_opcode), .funct3(dec_funct3), .funct7(dec_funct7),
        .rs1(dec_rs1), .rs2(dec_rs2), .rd(dec_rd), .format(dec_format),
        .illegal(dec_illegal), .imm(dec_imm),
        .id_valid, .id_pc, .id_opcode, .id_funct3, .id_funct7, .id_rs1, .id_rs2,
        .id_rd, .id_format, .id_imm, .id_target, .id_illegal
    );

endmodule

`default_nettype wire

/* source/rv32i_pkg.sv */
/*
 * Shared RV32I definitions for the pipeline front end
 * Opcodes, formats, the instruction word union and fixed words
 */
`default_nettype none

package rv32i_pkg;

    // PC after reset and the flush filler, ADDI x0, x0, 0
    localparam logic [31:0] reset_vector = 32'h60;
    localparam logic [31:0] nop_instr    = 32'h13;

    typedef logic [4:0] rv32i_reg_t;

    // Base opcodes, all with the low bits at 2'b11
    typedef enum logic [6:0] {
        opc_lui      = 7'b0110111,
        opc_auipc    = 7'b0010111,
        opc_jal      = 7'b1101111,
        opc_jalr     = 7'b1100111,
        opc_branch   = 7'b1100011,
        opc_load     = 7'b0000011,
        opc_store    = 7'b0100011,
        opc_op_imm   = 7'b0010011,
        opc_op       = 7'b0110011,
        opc_misc_mem = 7'b0001111,
        opc_system   = 7'b1110011
    } rv32i_opcode_e;

    typedef enum logic [2:0] {
        fmt_r = 3'd0,
        fmt_i = 3'd1,
        fmt_s = 3'd2,
        fmt_b = 3'd3,
        fmt_u = 3'd4,
        fmt_j = 3'd5
    } instr_format_e;

    // One struct per encoding, fields listed from bit 31 down
    typedef struct packed {
        logic [6:0] funct7;
        rv32i_reg_t rs2;
        rv32i_reg_t rs1;
        logic [2:0] funct3;
        rv32i_reg_t rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        rv32i_reg_t  rs1;
        logic [2:0]  funct3;
        rv32i_reg_t  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        rv32i_reg_t rs2;
        rv32i_reg_t rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    // Branch offset bits are scattered, bit 0 is implied zero
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        rv32i_reg_t rs2;
        rv32i_reg_t rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        rv32i_reg_t  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        rv32i_reg_t rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } rv32i_instr_u;

endpackage

`default_nettype wire

/* tb/tb_rv32i_front_end.sv */
/*
 * Testbench for the RV32I front end
 * Sequential fetch, stall pulses and redirects against a reference decoder
 */
`default_nettype none

module tb_rv32i_front_end;
    timeunit 1ns;
    timeprecision 1ps;
    import rv32i_pkg::*;

    localparam int imem_depth     = 256;
    localparam int seq_count      = 60;
    localparam int stall_pulses   = 20;
    localparam int redirect_count = 12;
    localparam int instr_total    = 1 + seq_count + 2 * stall_pulses + 3 * redirect_count;
    // Longest fetch is 5 cycles, plus stall and redirect cycles, doubled
    localparam int cycle_limit    = 2 * (instr_total * 5 + 4 * stall_pulses
                                         + 6 * redirect_count + 8);

    logic        clk = 1'b0;
    logic        rst;
    logic        stall;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic        wb_cyc;
    logic        wb_stb;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat;
    logic        wb_ack;
    logic        id_valid;
    logic [31:0] id_pc;
    logic [6:0]  id_opcode;
    logic [2:0]  id_funct3;
    logic [6:0]  id_funct7;
    logic [4:0]  id_rs1;
    logic [4:0]  id_rs2;
    logic [4:0]  id_rd;
    logic [2:0]  id_format;
    logic [31:0] id_imm;
    logic [31:0] id_target;
    logic        id_illegal;

    integer      seed = 32'h2d69;
    string       cur_test = "reset";
    int          checks = 0;
    int          errors = 0;
    int          test_checks = 0;
    int          test_errors = 0;
    int          valid_count = 0;
    int          cycle_count = 0;
    logic [31:0] exp_pc = reset_vector;
    logic [31:0] exp_adr = reset_vector;
    logic        last_rst = 1'b1;
    logic        last_stall = 1'b0;
    logic        last_redirect = 1'b0;
    logic [31:0] saved_pc;
    logic [31:0] saved_imm;
    logic [31:0] saved_target;
    logic [31:0] saved_fields;
    logic [4:0]  saved_flags;
    logic [31:0] new_pc;
    logic        with_stall;

    always #4 clk = ~clk;

    rv32i_front_end i_rv32i_front_end (
        .clk, .rst, .stall, .redirect, .redirect_pc,
        .wb_cyc, .wb_stb, .wb_adr, .wb_dat_i(wb_dat), .wb_ack,
        .id_valid, .id_pc, .id_opcode, .id_funct3, .id_funct7, .id_rs1, .id_rs2,
        .id_rd, .id_format, .id_imm, .id_target, .id_illegal
    );

    wb_imem_model #(.depth(imem_depth), .max_wait(3)) i_wb_imem_model (
        .clk, .rst, .wb_cyc, .wb_stb, .wb_adr, .wb_dat, .wb_ack
    );

    // Known opcode flag and format, straight from the RV32I base encoding
    function automatic logic [3:0] classify(input logic [6:0] op);
        case (op)
            7'b0110011:             return {1'b1, fmt_r};
            7'b0010011, 7'b0000011,
            7'b1100111, 7'b0001111,
            7'b1110011:             return {1'b1, fmt_i};
            7'b0100011:             return {1'b1, fmt_s};
            7'b1100011:             return {1'b1, fmt_b};
            7'b0110111, 7'b0010111: return {1'b1, fmt_u};
            7'b1101111:             return {1'b1, fmt_j};
            default:                return 4'd0;
        endcase
    endfunction

    function automatic logic [31:0] ref_imm(input logic [31:0] w, input logic [2:0] fmt);
        case (fmt)
            fmt_i:   return {{20{w[31]}}, w[31:20]};
            fmt_s:   return {{20{w[31]}}, w[31:25], w[11:7]};
            fmt_b:   return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            fmt_u:   return {w[31:12], 12'd0};
            fmt_j:   return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default: return 32'd0;
        endcase
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("ERROR %s %s: expected %h, actual %h", cur_test, what, expected, actual);
        end
    endtask

    task automatic check_decode();
        logic [31:0] w;
        logic [3:0]  cls;
        logic [2:0]  fmt;
        logic [31:0] imm;
        logic        has_rs2;
        logic        has_rd;
        w       = i_wb_imem_model.mem[(exp_pc >> 2) % imem_depth];
        cls     = classify(w[6:0]);
        fmt     = cls[2:0];
        imm     = ref_imm(w, fmt);
        has_rs2 = (fmt == fmt_r) || (fmt == fmt_s) || (fmt == fmt_b);
        has_rd  = !((fmt == fmt_s) || (fmt == fmt_b));
        check_value("pc order", exp_pc, id_pc);
        check_value("opcode", {25'd0, w[6:0]}, {25'd0, id_opcode});
        check_value("illegal", {31'd0, !cls[3]}, {31'd0, id_illegal});
        // Field layout of an unknown opcode is left open
        if (cls[3]) begin
            check_value("format", {29'd0, fmt}, {29'd0, id_format});
            check_value("funct3", {29'd0, w[14:12]}, {29'd0, id_funct3});
            check_value("funct7", (fmt == fmt_r) ? {25'd0, w[31:25]} : 32'd0,
                        {25'd0, id_funct7});
            check_value("rs1", {27'd0, w[19:15]}, {27'd0, id_rs1});
            check_value("rs2", has_rs2 ? {27'd0, w[24:20]} : 32'd0, {27'd0, id_rs2});
            check_value("rd", has_rd ? {27'd0, w[11:7]} : 32'd0, {27'd0, id_rd});
            check_value("imm", imm, id_imm);
            check_value("target", (fmt == fmt_b || fmt == fmt_j) ? exp_pc + imm : 32'd0,
                        id_target);
        end
        exp_pc = exp_pc + 32'd4;
        valid_count++;
    endtask

    // Outputs seen at an edge were loaded at the edge before, under last_ inputs
    always @(posedge clk) begin
        if (rst) begin
            check_value("reset outputs", 32'd0, {29'd0, wb_cyc, wb_stb, id_valid});
        end else begin
            if (last_rst) begin
                check_value("release outputs", 32'd0, {29'd0, wb_cyc, wb_stb, id_valid});
            end
            if (wb_cyc) begin
                check_value("bus address", exp_adr, wb_adr);
            end
            if (last_redirect) begin
                check_value("flushed valid", 32'd0, {31'd0, id_valid});
            end else if (last_stall) begin
                check_value("stall pc", saved_pc, id_pc);
                check_value("stall imm", saved_imm, id_imm);
                check_value("stall target", saved_target, id_target);
                check_value("stall fields", saved_fields,
                            {id_opcode, id_funct3, id_funct7, id_rs1, id_rs2, id_rd});
                check_value("stall flags", {27'd0, saved_flags},
                            {27'd0, id_valid, id_format, id_illegal});
            end else if (id_valid) begin
                check_decode();
            end
            if (redirect) begin
                exp_adr = redirect_pc;
                exp_pc  = redirect_pc;
            end else if (wb_cyc && wb_ack) begin
                exp_adr = exp_adr + 32'd4;
            end
        end
        last_rst      = rst;
        last_stall    = stall;
        last_redirect = redirect;
        saved_pc      = id_pc;
        saved_imm     = id_imm;
        saved_target  = id_target;
        saved_fields  = {id_opcode, id_funct3, id_funct7, id_rs1, id_rs2, id_rd};
        saved_flags   = {id_valid, id_format, id_illegal};
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic wait_instrs(input int n);
        int target;
        target = valid_count + n;
        while (valid_count < target) begin
            @(negedge clk);
        end
    endtask

    task automatic end_test(input string next_test);
        $display("Test %s done: %0d checks, %0d errors", cur_test,
                 checks - test_checks, errors - test_errors);
        test_checks = checks;
        test_errors = errors;
        cur_test    = next_test;
    endtask

    initial begin
        rst         = 1'b1;
        stall       = 1'b0;
        redirect    = 1'b0;
        redirect_pc = 32'd0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        wait_instrs(1);
        end_test("sequential");

        wait_instrs(seq_count);
        end_test("stall");

        repeat (stall_pulses) begin
            stall = 1'b1;
            repeat (1 + ($random(seed) & 3)) @(negedge clk);
            stall = 1'b0;
            wait_instrs(2);
        end
        end_test("redirect");

        // Some redirects land while the pipeline is stalled
        repeat (redirect_count) begin
            new_pc     = (($random(seed) & 32'h7fffffff) % imem_depth) * 4;
            with_stall = $random(seed) & 1;
            if (with_stall) begin
                stall = 1'b1;
                @(negedge clk);
            end
            redirect    = 1'b1;
            redirect_pc = new_pc;
            @(negedge clk);
            redirect = 1'b0;
            if (with_stall) begin
                repeat (2) @(negedge clk);
                stall = 1'b0;
            end
            wait_instrs(3);
        end
        end_test("summary");

        $display("Summary: %0d checks, %0d errors, %0d instructions decoded",
                 checks, errors, valid_count);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/wb_imem_model.sv */
/*
 * Wishbone classic read-only instruction memory for simulation
 * Seeded random contents and 0 to max_wait wait states per read
 */
`default_nettype none

module wb_imem_model #(
    parameter int depth    = 256,
    parameter int max_wait = 3
) (
    input  wire         clk,
    input  wire         rst,
    input  wire         wb_cyc,
    input  wire         wb_stb,
    input  wire  [31:0] wb_adr,
    output logic [31:0] wb_dat,
    output logic        wb_ack
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] mem [depth];
    logic [6:0]  opcodes [11];
    integer      seed = 32'h2d69;
    logic        busy;
    int unsigned wait_left;
    int unsigned draw;

    initial begin
        opcodes = '{7'b0110111, 7'b0010111, 7'b1101111, 7'b1100111, 7'b1100011,
                    7'b0000011, 7'b0100011, 7'b0010011, 7'b0110011, 7'b0001111,
                    7'b1110011};
        for (int i = 0; i < depth; i++) begin
            mem[i] = $random(seed);
            // Roughly one word in eight gets a real opcode
            if (($random(seed) & 7) == 0) begin
                draw = ($random(seed) & 32'h7fffffff) % 11;
                mem[i][6:0] = opcodes[draw];
            end
        end
    end

    // One read at a time, a dropped cyc discards the pending request
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_ack    <= 1'b0;
            wb_dat    <= 32'd0;
            busy      <= 1'b0;
            wait_left <= 0;
        end else if (wb_ack || !(wb_cyc && wb_stb)) begin
            wb_ack <= 1'b0;
            busy   <= 1'b0;
        end else if (!busy) begin
            draw = ($random(seed) & 32'h7fffffff) % (max_wait + 1);
            if (draw == 0) begin
                wb_ack <= 1'b1;
                wb_dat <= mem[(wb_adr >> 2) % depth];
            end else begin
                busy      <= 1'b1;
                wait_left <= draw;
            end
        end else if (wait_left == 1) begin
            wb_ack <= 1'b1;
            wb_dat <= mem[(wb_adr >> 2) % depth];
            busy   <= 1'b0;
        end else begin
            wait_left <= wait_left - 1;
        end
    end

endmodule

`default_nettype wire
